//--- rtl/glb_writer.sv
`timescale 1ns/100ps

module glb_writer
  import opsum_pkg::*;
#(
  parameter glb_addr_t GLB_BASE = 16'h0100
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      drain,
  input  logic      has_data,
  input  glb_word_t beat_word,
  output logic      busy,
  output logic      beat_done,
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output glb_addr_t wb_adr,
  output glb_word_t wb_dat_o,
  output logic [3:0] wb_sel,
  input  logic      wb_ack
);

  wr_state_t state;
  wr_state_t state_nxt;
  logic      load_word;

  // ------------------------------
  // bus outputs, decoded from state
  // ------------------------------
  assign wb_cyc = (state == wr_request) || (state == wr_wait_ack);
  assign wb_stb = wb_cyc;
  assign wb_we  = wb_cyc;   // write-only master
  assign wb_sel = 4'hf;

  assign busy      = (state != wr_idle);
  assign beat_done = wb_cyc && wb_ack;  // one pulse per ack

  // ------------------------------
  // drain FSM
  // ------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      wr_idle: begin
        if (drain) begin
          // empty buffer still shows busy for one cycle via gap
          state_nxt = has_data ? wr_request : wr_gap;
        end
      end
      wr_request: begin
        state_nxt = wb_ack ? wr_gap : wr_wait_ack;
      end
      wr_wait_ack: begin
        if (wb_ack) begin
          state_nxt = wr_gap;
        end
      end
      wr_gap: begin
        state_nxt = has_data ? wr_request : wr_idle;
      end
      default: state_nxt = wr_idle;
    endcase
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state <= wr_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // request is never re-entered from itself, so this is the entry edge
  assign load_word = (state_nxt == wr_request);

  always_ff @(posedge clk) begin
    if (load_word) begin
      wb_dat_o <= beat_word;  // held until ack
    end
  end

  // ------------------------------
  // GLB address counter
  // ------------------------------

  // keeps counting across drains
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wb_adr <= GLB_BASE;
    end else if (beat_done) begin
      wb_adr <= wb_adr + 1'b1;
    end
  end

  // slow slave only stretches the cycle; data and address stay put
  a_hold_until_ack: assert property (
    @(posedge clk) disable iff (!reset)
    wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr) && $stable(wb_dat_o)
  );

endmodule

//--- rtl/opsum_buffer.sv
`timescale 1ns/100ps

module opsum_buffer
  import opsum_pkg::*;
#(
  parameter int ROW_NUM    = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      red_valid,
  input  psum_t [ROW_NUM-1:0]       red_sum,
  output logic                      store_ready,
  input  logic                      busy,
  output logic                      has_data,
  output glb_word_t                 beat_word,
  input  logic                      beat_done
);

  localparam int OCC_W  = $clog2(FIFO_DEPTH + 1);
  localparam int SLOT_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int BEAT_W = (ROW_NUM > 2) ? $clog2(ROW_NUM / 2) : 1;
  localparam int ROW_W  = BEAT_W + 1;

  // slot 0 holds the newest set, slot occ-1 the oldest
  psum_t [FIFO_DEPTH-1:0] fifo [ROW_NUM];

  logic [OCC_W-1:0]  occ;
  logic [BEAT_W-1:0] beat;
  logic              last_beat;
  logic              store;
  logic              pop;
  logic [SLOT_W-1:0] rd_slot;
  logic [ROW_W-1:0]  row_lo;
  logic [ROW_W-1:0]  row_hi;

  // ------------------------------
  // store side
  // ------------------------------

  // no stores during a drain, so stores and pops never meet
  assign store_ready = !busy && (occ != OCC_W'(FIFO_DEPTH));
  assign store       = red_valid && store_ready;

  for (genvar r = 0; r < ROW_NUM; r++) begin : g_row
    always_ff @(posedge clk) begin
      if (store) begin
        fifo[r][0] <= red_sum[r];
        for (int k = 1; k < FIFO_DEPTH; k++) begin
          fifo[r][k] <= fifo[r][k-1];  // older sets move one slot down
        end
      end
    end
  end

  // ------------------------------
  // occupancy and beat counter
  // ------------------------------
  assign last_beat = (beat == BEAT_W'(ROW_NUM / 2 - 1));
  assign pop       = beat_done && last_beat;  // last row pair of the oldest set
  assign has_data  = (occ != '0);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      occ <= '0;
    end else if (store) begin
      occ <= occ + 1'b1;
    end else if (pop) begin
      occ <= occ - 1'b1;  // oldest set dropped and no data moves
    end
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      beat <= '0;
    end else if (beat_done) begin
      if (last_beat) begin
        beat <= '0;
      end else begin
        beat <= beat + 1'b1;
      end
    end
  end

  // ------------------------------
  // beat word select
  // ------------------------------

  // oldest occupied slot; partly filled FIFOs drain from the right place
  assign rd_slot = (occ == '0) ? '0 : SLOT_W'(occ - 1'b1);
  assign row_lo  = {beat, 1'b0};
  assign row_hi  = {beat, 1'b1};

  always_comb begin
    beat_word = {fifo[row_hi][rd_slot], fifo[row_lo][rd_slot]};  // lower row low
  end

  // ------------------------------
  // checks
  // ------------------------------

  // writer only acks while draining a buffer that has something in it
  a_pop_with_data: assert property (
    @(posedge clk) disable iff (!reset)
    beat_done |-> has_data && busy
  );

  // a store never lands on a pop cycle
  a_store_no_pop: assert property (
    @(posedge clk) disable iff (!reset)
    store |-> !beat_done
  );

endmodule

//--- rtl/opsum_pkg.sv
package opsum_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int PSUM_W = 16;           // one row partial sum
  localparam int WORD_W = 32;           // one GLB data word, two rows
  localparam int ADDR_W = 16;           // GLB word address

  // ------------------------------
  // data types
  // ------------------------------

  // signed partial sum coming out of the PE array
  typedef logic signed [PSUM_W-1:0] psum_t;

  // GLB word; lower row of the pair sits in bits [15:0]
  typedef logic [WORD_W-1:0] glb_word_t;

  // GLB word address
  typedef logic [ADDR_W-1:0] glb_addr_t;

  // saturation limits for psum_t
  localparam psum_t PSUM_MAX = {1'b0, {(PSUM_W-1){1'b1}}};
  localparam psum_t PSUM_MIN = {1'b1, {(PSUM_W-1){1'b0}}};

  // ------------------------------
  // writer FSM
  // ------------------------------
  typedef enum logic [1:0] {
    wr_idle,      // waiting for drain
    wr_request,   // first cycle of a bus cycle
    wr_wait_ack,  // holding the bus cycle
    wr_gap        // cyc low for one cycle after ack
  } wr_state_t;

endpackage

//--- rtl/opsum_unit.sv
`timescale 1ns/100ps

module opsum_unit
  import opsum_pkg::*;
#(
  parameter int        ROW_NUM    = 8,
  parameter int        FIFO_DEPTH = 4,
  parameter glb_addr_t GLB_BASE   = 16'h0100
) (
  input  logic                 clk,
  input  logic                 reset,
  // PE array side
  input  logic                 in_valid,
  input  psum_t [ROW_NUM-1:0]  psum_a,
  input  psum_t [ROW_NUM-1:0]  psum_b,
  output logic                 in_ready,
  // drain control
  input  logic                 drain,
  output logic                 busy,
  // GLB, Wishbone classic master
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output glb_addr_t            wb_adr,
  output glb_word_t            wb_dat_o,
  output logic [3:0]           wb_sel,
  input  logic                 wb_ack
);

  // ------------------------------
  // internal links
  // ------------------------------
  logic                red_valid;
  psum_t [ROW_NUM-1:0] red_sum;
  logic                store_ready;
  logic                has_data;
  glb_word_t           beat_word;
  logic                beat_done;

  psum_reducer #(
    .ROW_NUM     (ROW_NUM)
  ) reducer0 (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .psum_a      (psum_a),
    .psum_b      (psum_b),
    .in_ready    (in_ready),
    .red_valid   (red_valid),
    .red_sum     (red_sum),
    .store_ready (store_ready)
  );

  opsum_buffer #(
    .ROW_NUM     (ROW_NUM),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) buffer0 (
    .clk         (clk),
    .reset       (reset),
    .red_valid   (red_valid),
    .red_sum     (red_sum),
    .store_ready (store_ready),
    .busy        (busy),        // stores blocked while draining
    .has_data    (has_data),
    .beat_word   (beat_word),
    .beat_done   (beat_done)
  );

  glb_writer #(
    .GLB_BASE    (GLB_BASE)
  ) writer0 (
    .clk         (clk),
    .reset       (reset),
    .drain       (drain),
    .has_data    (has_data),
    .beat_word   (beat_word),
    .busy        (busy),
    .beat_done   (beat_done),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_o    (wb_dat_o),
    .wb_sel      (wb_sel),
    .wb_ack      (wb_ack)
  );

endmodule

//--- rtl/psum_reducer.sv
`timescale 1ns/100ps

module psum_reducer
  import opsum_pkg::*;
#(
  parameter int ROW_NUM = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_valid,
  input  psum_t [ROW_NUM-1:0]       psum_a,
  input  psum_t [ROW_NUM-1:0]       psum_b,
  output logic                      in_ready,
  output logic                      red_valid,
  output psum_t [ROW_NUM-1:0]       red_sum,
  input  logic                      store_ready
);

  psum_t [ROW_NUM-1:0] sum_next;
  logic                load;

  // add with one extra bit, clamp when the sign bits disagree
  function automatic psum_t sat_add(input psum_t a, input psum_t b);
    logic signed [PSUM_W:0] wide;
    wide = {a[PSUM_W-1], a} + {b[PSUM_W-1], b};
    if (wide[PSUM_W] != wide[PSUM_W-1]) begin
      return wide[PSUM_W] ? PSUM_MIN : PSUM_MAX;
    end
    return wide[PSUM_W-1:0];
  endfunction

  // ------------------------------
  // row-wise saturating add
  // ------------------------------
  always_comb begin
    for (int r = 0; r < ROW_NUM; r++) begin
      sum_next[r] = sat_add(psum_a[r], psum_b[r]);
    end
  end

  // free slot, or the held sum leaves this cycle
  assign in_ready = !red_valid || store_ready;
  assign load     = in_valid && in_ready;

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      red_valid <= 1'b0;
    end else if (load) begin
      red_valid <= 1'b1;
    end else if (store_ready) begin
      red_valid <= 1'b0;          // taken by the buffer
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      red_sum <= sum_next;
    end
  end

  // a refused sum must wait unchanged for the buffer
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!reset)
    red_valid && !store_ready |=> red_valid && $stable(red_sum)
  );

endmodule

//--- tb.f
rtl/opsum_pkg.sv
rtl/psum_reducer.sv
rtl/opsum_buffer.sv
rtl/glb_writer.sv
rtl/opsum_unit.sv
tests/glb_mem_model.sv
tests/tb_opsum_unit.sv

//--- tests/glb_mem_model.sv
`timescale 1ns/100ps

module glb_mem_model
  import opsum_pkg::*;
#(
  parameter int SEED      = 32'h7716e8a5,
  parameter int MAX_DELAY = 5
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  glb_addr_t  wb_adr,
  input  glb_word_t  wb_dat_i,
  input  logic [3:0] wb_sel,
  output logic       wb_ack,
  output logic       wr_seen,   // one pulse per recorded write
  output glb_addr_t  wr_adr,
  output glb_word_t  wr_dat,
  output logic [3:0] wr_sel,
  output int         wr_count
);

  int seed;
  int delay;      // wait cycles before the next ack
  int wait_cnt;

  initial seed = SEED;

  always @(posedge clk or negedge reset) begin
    if (!reset) begin
      wb_ack   <= 1'b0;
      wr_seen  <= 1'b0;
      wr_adr   <= '0;
      wr_dat   <= '0;
      wr_sel   <= '0;
      wr_count <= 0;
      wait_cnt <= 0;
      delay    <= {$random(seed)} % (MAX_DELAY + 1);
    end else begin
      wr_seen <= 1'b0;
      if (wb_ack) begin
        wb_ack <= 1'b0;                   // single-cycle ack
      end else if (wb_cyc && wb_stb) begin
        if (wait_cnt >= delay) begin
          wb_ack   <= 1'b1;
          wr_seen  <= wb_we;
          wr_adr   <= wb_adr;             // master holds these until ack
          wr_dat   <= wb_dat_i;
          wr_sel   <= wb_sel;
          wr_count <= wr_count + (wb_we ? 1 : 0);
          wait_cnt <= 0;
          delay    <= {$random(seed)} % (MAX_DELAY + 1);
        end else begin
          wait_cnt <= wait_cnt + 1;
        end
      end
    end
  end

endmodule

//--- tests/tb_opsum_unit.sv
`timescale 1ns/100ps

module tb_opsum_unit
  import opsum_pkg::*;
();

  localparam int        ROWS         = 8;
  localparam glb_addr_t BASE         = 16'h0100;
  localparam int        ACCEPT_LIMIT = 200;
  localparam int        DRAIN_LIMIT  = 400;

  logic clk, reset, in_valid, in_ready, drain, busy;
  logic wb_cyc, wb_stb, wb_we, wb_ack, wr_seen;
  logic [3:0] wb_sel, wr_sel;
  psum_t [ROWS-1:0] psum_a, psum_b;
  glb_addr_t wb_adr, wr_adr;
  glb_word_t wb_dat_o, wr_dat;
  int        wr_count;

  glb_word_t exp_dat [$];   // expected words in write order
  glb_addr_t exp_adr [$];
  glb_addr_t next_adr = BASE;
  int        seed     = 32'h7716e8a5;

  opsum_unit #(.ROW_NUM(ROWS), .FIFO_DEPTH(4), .GLB_BASE(BASE)) dut0 (
    .clk(clk), .reset(reset), .in_valid(in_valid), .psum_a(psum_a), .psum_b(psum_b),
    .in_ready(in_ready), .drain(drain), .busy(busy), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
    .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_ack(wb_ack)
  );

  glb_mem_model #(.SEED(32'h7716e8a5)) glb0 (
    .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_i(wb_dat_o), .wb_sel(wb_sel), .wb_ack(wb_ack),
    .wr_seen(wr_seen), .wr_adr(wr_adr), .wr_dat(wr_dat), .wr_sel(wr_sel),
    .wr_count(wr_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // error exits
  // ------------------------------
  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, got);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("error at %0t ns: %s", $time, why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic int clamp_sum(input int x, input int y);
    int s;
    s = x + y;
    if (s > 32767) s = 32767;
    else if (s < -32768) s = -32768;
    return s;
  endfunction

  // word for one row pair with the lower row in the low half
  function automatic glb_word_t ref_word(input psum_t [ROWS-1:0] a,
                                         input psum_t [ROWS-1:0] b, input int pair);
    int lo;
    int hi;
    lo = clamp_sum(a[2*pair], b[2*pair]);
    hi = clamp_sum(a[2*pair+1], b[2*pair+1]);
    return {hi[15:0], lo[15:0]};
  endfunction

  task automatic push_expected(input psum_t [ROWS-1:0] a, input psum_t [ROWS-1:0] b);
    for (int p = 0; p < ROWS / 2; p++) begin
      exp_dat.push_back(ref_word(a, b, p));
      exp_adr.push_back(next_adr);
      next_adr++;
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic make_set(input bit with_ovf, output psum_t [ROWS-1:0] a,
                          output psum_t [ROWS-1:0] b);
    for (int r = 0; r < ROWS; r++) begin
      a[r] = psum_t'($random(seed));
      b[r] = psum_t'($random(seed));
    end
    if (with_ovf) begin
      a[0] = 16'sd30000;    // positive overflow
      b[0] = 16'sd5000;
      a[1] = -16'sd30000;   // negative overflow
      b[1] = -16'sd5000;
      a[2] = PSUM_MAX;
      b[2] = PSUM_MAX;
      a[3] = PSUM_MIN;
      b[3] = PSUM_MIN;
    end
  endtask

  task automatic send_set(input psum_t [ROWS-1:0] a, input psum_t [ROWS-1:0] b);
    int t;
    @(posedge clk);
    in_valid <= 1'b1;
    psum_a   <= a;
    psum_b   <= b;
    t = 0;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
      t++;
      if (t > ACCEPT_LIMIT) abort_run("timeout waiting for in_ready");
    end
    @(posedge clk);  // taken on this edge
    in_valid <= 1'b0;
    push_expected(a, b);
  endtask

  task automatic run_drain(input int n_words);
    int t;
    int start_cnt;
    @(negedge clk);
    start_cnt = wr_count;
    @(posedge clk);
    drain <= 1'b1;
    @(posedge clk);
    drain <= 1'b0;
    @(negedge clk);
    assert (busy) else abort_run("busy did not rise after drain");
    t = 0;
    while (busy) begin
      @(negedge clk);
      t++;
      if (t > DRAIN_LIMIT) abort_run("timeout waiting for busy to fall");
    end
    assert (wr_count - start_cnt == n_words)
      else value_error("write count", n_words, wr_count - start_cnt);
    assert (n_words != 0 || t == 1) else abort_run("empty drain kept busy too long");
  endtask

  // ------------------------------
  // compare process
  // ------------------------------
  always @(posedge clk) begin
    if (reset && wr_seen) begin
      assert (exp_dat.size() != 0) else abort_run("GLB write with no expected word");
      assert (busy) else abort_run("busy low before the last write of a drain");
      assert (wr_sel == 4'hf) else value_error("wb_sel", 4'hf, wr_sel);
      assert (wr_adr == exp_adr[0]) else value_error("wb_adr", exp_adr[0], wr_adr);
      assert (wr_dat == exp_dat[0]) else value_error("wb_dat_o", exp_dat[0], wr_dat);
      void'(exp_adr.pop_front());
      void'(exp_dat.pop_front());
    end
  end

  initial begin
    psum_t [ROWS-1:0] a;
    psum_t [ROWS-1:0] b;
    reset    = 1'b0;
    in_valid = 1'b0;
    drain    = 1'b0;
    psum_a   = '0;
    psum_b   = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    assert (!wb_cyc && !wb_stb) else abort_run("bus cycle active after reset");
    assert (!busy) else abort_run("busy high after reset");
    assert (in_ready) else abort_run("in_ready low after reset");

    // three sets drained oldest first
    for (int i = 0; i < 3; i++) begin
      make_set(i == 0, a, b);
      send_set(a, b);
    end
    repeat (2) @(posedge clk);   // last set into the FIFO
    run_drain(3 * ROWS / 2);
    run_drain(0);                // nothing stored

    // fifth set parks in the reducer stage once the buffer is full
    for (int i = 0; i < 5; i++) begin
      make_set(i == 1, a, b);
      send_set(a, b);
    end
    repeat (5) begin
      @(negedge clk);
      assert (!in_ready) else abort_run("in_ready high with a full buffer");
    end
    run_drain(4 * ROWS / 2);
    repeat (2) @(posedge clk);   // held set moves into the FIFO
    run_drain(ROWS / 2);

    repeat (4) @(posedge clk);
    if (exp_dat.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("%0d expected words were never written", exp_dat.size());
      $display("** FAIL **");
      $fatal(1);
    end
  end

endmodule
